// ==== Bender.yml ====
package:
  name: shooter

sources:
  - hw/shooter_pkg.sv
  - hw/tank_motion.sv
  - hw/tank_gun.sv
  - hw/monster_row.sv
  - hw/pixel_painter.sv
  - hw/shooter_top.sv
  - target: test
    files:
      - tests/shooter_tb.sv

// ==== filelist.f ====
hw/shooter_pkg.sv
hw/tank_motion.sv
hw/tank_gun.sv
hw/monster_row.sv
hw/pixel_painter.sv
hw/shooter_top.sv
tests/shooter_tb.sv

// ==== hw/monster_row.sv ====
`timescale 1ns/1ps

module monster_row (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      restart,
	input  shooter_pkg::bullet_slot_t bullets,
	output shooter_pkg::hit_t         hits,
	output shooter_pkg::mons_flags_t  destroyed
);

	import shooter_pkg::*;

	mons_flags_t mons_hit;

	// a live bullet on the monster row inside a surviving monster's width
	always_comb begin
		hits     = '0;
		mons_hit = '0;
		for (int b = 0; b < NUM_BULLETS; b++) begin
			for (int m = 0; m < NUM_MONSTERS; m++) begin
				if (bullets[b].alive && !destroyed[m] &&
				    (bullets[b].pos.y == MONS_Y) &&
				    (bullets[b].pos.x >= MONS_X[m] - MONS_HALF_W) &&
				    (bullets[b].pos.x <= MONS_X[m] + MONS_HALF_W)) begin
					hits[b]     = 1'b1;
					mons_hit[m] = 1'b1;
				end
			end
		end
	end

	// flags are sticky until the next restart
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			destroyed <= '0;
		end else if (restart) begin
			destroyed <= '0;
		end else begin
			destroyed <= destroyed | mons_hit;
		end
	end

	a_flags_sticky: assert property (
		@(posedge clk) disable iff (rst)
		!restart |=> ((destroyed & $past(destroyed)) == $past(destroyed))
	) else $error("destroyed flag dropped without restart");

endmodule

// ==== hw/pixel_painter.sv ====
`timescale 1ns/1ps

module pixel_painter (
	input  logic                      bright,
	input  shooter_pkg::coord_t       h_count,
	input  shooter_pkg::coord_t       v_count,
	input  shooter_pkg::coord_t       tank_x,
	input  shooter_pkg::bullet_slot_t bullets,
	input  shooter_pkg::mons_flags_t  destroyed,
	output shooter_pkg::rgb_t         rgb
);

	import shooter_pkg::*;

	logic on_bullet;
	logic on_tank_head;
	logic on_tank_body;
	logic on_monster;

	// raster inside a box of half sizes hw, hh around (cx, cy)
	function automatic logic in_box(
		input coord_t h,
		input coord_t v,
		input coord_t cx,
		input coord_t cy,
		input coord_t hw,
		input coord_t hh
	);
		return (h >= cx - hw) && (h <= cx + hw) && (v >= cy - hh) && (v <= cy + hh);
	endfunction

	always_comb begin
		on_bullet = 1'b0;
		for (int i = 0; i < NUM_BULLETS; i++) begin
			if (bullets[i].alive && in_box(h_count, v_count, bullets[i].pos.x,
			                               bullets[i].pos.y, BULLET_HALF, BULLET_HALF)) begin
				on_bullet = 1'b1;
			end
		end
	end

	// head sits just above the tank row, body hangs below it
	assign on_tank_head = (v_count >= TANK_Y - TANK_HEAD_H) && (v_count < TANK_Y) &&
	                      (h_count >= tank_x - TANK_HEAD_HALF_W) &&
	                      (h_count <= tank_x + TANK_HEAD_HALF_W);
	assign on_tank_body = (v_count >= TANK_Y) && (v_count <= TANK_Y + TANK_BODY_H) &&
	                      (h_count >= tank_x - TANK_BODY_HALF_W) &&
	                      (h_count <= tank_x + TANK_BODY_HALF_W);

	always_comb begin
		on_monster = 1'b0;
		for (int m = 0; m < NUM_MONSTERS; m++) begin
			if (!destroyed[m] && in_box(h_count, v_count, MONS_X[m], MONS_Y,
			                            MONS_HALF_W, MONS_HALF_H)) begin
				on_monster = 1'b1;
			end
		end
	end

	always_comb begin
		if (!bright) begin
			rgb = COLOR_BLACK;
		end else if (destroyed == '1) begin
			// board cleared
			rgb = COLOR_CYAN;
		end else if (on_bullet) begin
			rgb = COLOR_BLUE;
		end else if (on_tank_head || on_tank_body) begin
			rgb = COLOR_GREEN;
		end else if (on_monster) begin
			rgb = COLOR_RED;
		end else begin
			rgb = COLOR_BLACK;
		end
	end

endmodule

// ==== hw/shooter_pkg.sv ====
package shooter_pkg;

	// object counts
	localparam int NUM_BULLETS  = 3;
	localparam int NUM_MONSTERS = 5;

	// raster and object coordinates
	typedef logic [9:0] coord_t;

	// centre of an object
	typedef struct packed {
		coord_t x;
		coord_t y;
	} obj_pos_t;

	typedef struct packed {
		logic     alive;
		obj_pos_t pos;
	} bullet_t;

	typedef bullet_t [NUM_BULLETS-1:0] bullet_slot_t;

	// one bit per bullet slot
	typedef logic [NUM_BULLETS-1:0] hit_t;

	// one destroyed flag per monster
	typedef logic [NUM_MONSTERS-1:0] mons_flags_t;

	// 4 bits each of red, green, blue
	typedef logic [11:0] rgb_t;

	// tank
	localparam coord_t TANK_X_START     = 10'd450;
	localparam coord_t TANK_Y           = 10'd450;
	localparam coord_t TANK_STEP        = 10'd2;
	localparam coord_t TANK_X_MIN       = 10'd150;
	localparam coord_t TANK_X_MAX       = 10'd800;
	localparam coord_t TANK_BODY_HALF_W = 10'd10;
	localparam coord_t TANK_BODY_H      = 10'd10;
	localparam coord_t TANK_HEAD_HALF_W = 10'd2;
	localparam coord_t TANK_HEAD_H      = 10'd5;

	// bullets, drawn as 3x3 squares
	localparam coord_t BULLET_HALF   = 10'd1;
	localparam coord_t BULLET_TOP_LO = 10'd32;
	localparam coord_t BULLET_TOP_HI = 10'd33;

	// monsters
	localparam coord_t MONS_Y      = 10'd100;
	localparam coord_t MONS_HALF_W = 10'd10;
	localparam coord_t MONS_HALF_H = 10'd5;
	localparam coord_t MONS_X [NUM_MONSTERS] = '{
		10'd250, 10'd350, 10'd450, 10'd550, 10'd650
	};

	// colours
	localparam rgb_t COLOR_BLACK = 12'h000;
	localparam rgb_t COLOR_RED   = 12'hf00;
	localparam rgb_t COLOR_GREEN = 12'h0f0;
	localparam rgb_t COLOR_BLUE  = 12'h00f;
	localparam rgb_t COLOR_CYAN  = 12'h0ff;

endpackage

// ==== hw/shooter_top.sv ====
`timescale 1ns/1ps

module shooter_top (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     bright,
	input  logic                     left,
	input  logic                     right,
	input  logic                     fire,
	input  logic                     restart,
	input  shooter_pkg::coord_t      h_count,
	input  shooter_pkg::coord_t      v_count,
	output shooter_pkg::rgb_t        rgb,
	output shooter_pkg::mons_flags_t monster_destroyed
);

	import shooter_pkg::*;

	coord_t       tank_x;
	bullet_slot_t bullets;
	hit_t         hits;

	tank_motion i_tank_motion (
		.clk     (clk),
		.rst     (rst),
		.restart (restart),
		.left    (left),
		.right   (right),
		.fire    (fire),
		.tank_x  (tank_x)
	);

	tank_gun i_tank_gun (
		.clk     (clk),
		.rst     (rst),
		.restart (restart),
		.fire    (fire),
		.tank_x  (tank_x),
		.hits    (hits),
		.bullets (bullets)
	);

	monster_row i_monster_row (
		.clk       (clk),
		.rst       (rst),
		.restart   (restart),
		.bullets   (bullets),
		.hits      (hits),
		.destroyed (monster_destroyed)
	);

	pixel_painter i_pixel_painter (
		.bright    (bright),
		.h_count   (h_count),
		.v_count   (v_count),
		.tank_x    (tank_x),
		.bullets   (bullets),
		.destroyed (monster_destroyed),
		.rgb       (rgb)
	);

endmodule

// ==== hw/tank_gun.sv ====
`timescale 1ns/1ps

module tank_gun (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      restart,
	input  logic                      fire,
	input  shooter_pkg::coord_t       tank_x,
	input  shooter_pkg::hit_t         hits,
	output shooter_pkg::bullet_slot_t bullets
);

	import shooter_pkg::*;

	logic [NUM_BULLETS-1:0] alive;
	logic [NUM_BULLETS-1:0] grant;
	logic [NUM_BULLETS-1:0] at_top;
	obj_pos_t               pos [NUM_BULLETS];

	// lowest dead slot takes the shot, none if all are flying
	always_comb begin
		grant = '0;
		for (int i = 0; i < NUM_BULLETS; i++) begin
			if (fire && !alive[i] && (grant == '0)) begin
				grant[i] = 1'b1;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_BULLETS; i++) begin
			at_top[i] = (pos[i].y >= BULLET_TOP_LO) && (pos[i].y <= BULLET_TOP_HI);
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			alive <= '0;
		end else if (restart) begin
			alive <= '0;
		end else begin
			for (int i = 0; i < NUM_BULLETS; i++) begin
				if (grant[i]) begin
					alive[i] <= 1'b1;
				end else if (alive[i] && (hits[i] || at_top[i])) begin
					// retire on a hit or on reaching the top band
					alive[i] <= 1'b0;
				end
			end
		end
	end

	// a new shot starts at the tank, live shots climb one row
	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_BULLETS; i++) begin
			if (grant[i]) begin
				pos[i].x <= tank_x;
				pos[i].y <= TANK_Y;
			end else if (alive[i]) begin
				pos[i].y <= pos[i].y - 10'd1;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_BULLETS; i++) begin
			bullets[i].alive = alive[i];
			bullets[i].pos   = pos[i];
		end
	end

	// top band retires a bullet before it can climb past it
	for (genvar g = 0; g < NUM_BULLETS; g++) begin : g_top_chk
		a_bullet_below_top: assert property (
			@(posedge clk) disable iff (rst)
			alive[g] |-> (pos[g].y >= BULLET_TOP_LO)
		) else $error("bullet %0d flew past the top band", g);
	end

endmodule

// ==== hw/tank_motion.sv ====
`timescale 1ns/1ps

module tank_motion (
	input  logic                clk,
	input  logic                rst,
	input  logic                restart,
	input  logic                left,
	input  logic                right,
	input  logic                fire,
	output shooter_pkg::coord_t tank_x
);

	import shooter_pkg::*;

	// fire freezes the tank for that cycle, right wins over left
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			tank_x <= TANK_X_START;
		end else if (restart) begin
			tank_x <= TANK_X_START;
		end else if (!fire) begin
			if (right) begin
				// wrap from the right edge back to the left
				if (tank_x == TANK_X_MAX) begin
					tank_x <= TANK_X_MIN;
				end else begin
					tank_x <= tank_x + TANK_STEP;
				end
			end else if (left) begin
				if (tank_x == TANK_X_MIN) begin
					tank_x <= TANK_X_MAX;
				end else begin
					tank_x <= tank_x - TANK_STEP;
				end
			end
		end
	end

	// the step divides the span, so the wrap points are always hit exactly
	a_tank_in_range: assert property (
		@(posedge clk) disable iff (rst)
		(tank_x >= TANK_X_MIN) && (tank_x <= TANK_X_MAX)
	) else $error("tank_x left the playfield: %0d", tank_x);

endmodule

// ==== tests/shooter_tb.sv ====
`timescale 1ns/1ps

module shooter_tb;

	import shooter_pkg::*;

	typedef enum int {A_IDLE, A_DARK, A_LEFT, A_RIGHT, A_FIRE, A_FIRE_RIGHT, A_SHOOT,
	                  A_RESTART} action_e;
	typedef enum int {P_ABS, P_TANK, P_SWEEP, P_SLOT0, P_SLOT1, P_SLOT2} probe_e;

	typedef struct packed {
		logic               bright;
		logic               left;
		logic               right;
		logic               fire;
		logic               restart;
		logic               until_hit;
		logic [2:0]         mode;
		logic [9:0]         hold;
		logic signed [10:0] ph;
		logic signed [10:0] pv;
		rgb_t               exp_rgb;
		mons_flags_t        exp_flags;
	} step_t;

	logic        clk;
	logic        rst;
	logic        bright;
	logic        left;
	logic        right;
	logic        fire;
	logic        restart;
	coord_t      h_count;
	coord_t      v_count;
	rgb_t        rgb;
	mons_flags_t monster_destroyed;

	step_t       steps [$];
	string       step_names [$];
	int          n_run;
	int          n_fail;

	// reference model state
	int          m_tank;
	logic        m_alive [NUM_BULLETS];
	int          m_bx [NUM_BULLETS];
	int          m_by [NUM_BULLETS];
	mons_flags_t m_flags;

	shooter_top i_dut (
		.clk               (clk),
		.rst               (rst),
		.bright            (bright),
		.left              (left),
		.right             (right),
		.fire              (fire),
		.restart           (restart),
		.h_count           (h_count),
		.v_count           (v_count),
		.rgb               (rgb),
		.monster_destroyed (monster_destroyed)
	);

	always #5 clk = ~clk;

	// game rules, stepped on every rising edge with the inputs driven at the falling edge
	always @(posedge clk or posedge rst) begin : ref_model
		logic [NUM_BULLETS-1:0] hit;
		mons_flags_t            new_flags;
		logic                   granted;
		if (rst || restart) begin
			m_tank = TANK_X_START;
			m_flags = '0;
			for (int b = 0; b < NUM_BULLETS; b++) begin
				m_alive[b] = 1'b0;
			end
		end else begin
			hit = '0;
			new_flags = m_flags;
			for (int b = 0; b < NUM_BULLETS; b++) begin
				for (int m = 0; m < NUM_MONSTERS; m++) begin
					if (m_alive[b] && !m_flags[m] && (m_by[b] == MONS_Y) &&
					    (m_bx[b] >= MONS_X[m] - MONS_HALF_W) &&
					    (m_bx[b] <= MONS_X[m] + MONS_HALF_W)) begin
						hit[b] = 1'b1;
						new_flags[m] = 1'b1;
					end
				end
			end
			granted = 1'b0;
			for (int b = 0; b < NUM_BULLETS; b++) begin
				if (fire && !m_alive[b] && !granted) begin
					m_alive[b] = 1'b1;
					m_bx[b] = m_tank;
					m_by[b] = TANK_Y;
					granted = 1'b1;
				end else if (m_alive[b]) begin
					if (hit[b] || ((m_by[b] >= BULLET_TOP_LO) && (m_by[b] <= BULLET_TOP_HI))) begin
						m_alive[b] = 1'b0;
					end else begin
						m_by[b] = m_by[b] - 1;
					end
				end
			end
			m_flags = new_flags;
			// fire freezes the tank, right wins over left
			if (!fire) begin
				if (right) begin
					m_tank = (m_tank == TANK_X_MAX) ? TANK_X_MIN : m_tank + TANK_STEP;
				end else if (left) begin
					m_tank = (m_tank == TANK_X_MIN) ? TANK_X_MAX : m_tank - TANK_STEP;
				end
			end
		end
	end

	task automatic add_step(input string name, input action_e act, input int hold,
	                        input probe_e mode, input int ph, input int pv,
	                        input rgb_t exp_rgb, input mons_flags_t exp_flags);
		step_t s;
		s = '0;
		s.bright = (act != A_DARK);
		s.left = (act == A_LEFT);
		s.right = (act == A_RIGHT) || (act == A_FIRE_RIGHT);
		s.fire = (act == A_FIRE) || (act == A_FIRE_RIGHT) || (act == A_SHOOT);
		s.restart = (act == A_RESTART);
		s.until_hit = (act == A_SHOOT);
		s.mode = mode;
		s.hold = hold;
		s.ph = ph;
		s.pv = pv;
		s.exp_rgb = exp_rgb;
		s.exp_flags = exp_flags;
		steps.push_back(s);
		step_names.push_back(name);
	endtask

	task automatic run_step(input step_t s, input string name);
		int   h;
		int   v;
		int   n;
		int   bad;
		rgb_t first_bad;
		logic ok;
		ok = 1'b1;
		@(negedge clk);
		bright = s.bright;
		left = s.left;
		right = s.right;
		fire = s.fire;
		restart = s.restart;
		if (s.until_hit) begin
			// one fire pulse, then wait for the bullet to land
			@(negedge clk);
			fire = 1'b0;
			n = 1;
			while ((monster_destroyed !== s.exp_flags) && (n < s.hold)) begin
				@(negedge clk);
				n++;
			end
			if (monster_destroyed !== s.exp_flags) begin
				$display("%s: monster flags never reached %b within %0d cycles",
				         name, s.exp_flags, s.hold);
				ok = 1'b0;
			end
		end else begin
			repeat (s.hold) @(negedge clk);
		end
		left = 1'b0;
		right = 1'b0;
		fire = 1'b0;
		restart = 1'b0;
		if (s.mode == P_SWEEP) begin
			// visible window of the usual 800x525 timing
			bad = 0;
			first_bad = '0;
			for (v = 35; v < 515; v++) begin
				for (h = 144; h < 784; h++) begin
					h_count = h;
					v_count = v;
					#1;
					if (rgb !== s.exp_rgb) begin
						if (bad == 0) begin
							first_bad = rgb;
						end
						bad++;
					end
				end
			end
			assert (bad == 0) else begin
				$display("FAILED %s: expected %h on all visible pixels, actual %h at %0d of them",
				         name, s.exp_rgb, first_bad, bad);
				ok = 1'b0;
			end
		end else begin
			h = s.ph;
			v = s.pv;
			if (s.mode == P_TANK) begin
				h = m_tank + s.ph;
			end else if (s.mode >= P_SLOT0) begin
				h = m_bx[s.mode - P_SLOT0] + s.ph;
				v = m_by[s.mode - P_SLOT0] + s.pv;
			end
			h_count = h;
			v_count = v;
			#1;
			assert (rgb === s.exp_rgb) else begin
				$display("FAILED %s: rgb at (%0d, %0d) expected %h, actual %h",
				         name, h, v, s.exp_rgb, rgb);
				ok = 1'b0;
			end
		end
		assert (monster_destroyed === s.exp_flags) else begin
			$display("FAILED %s: monster_destroyed expected %b, actual %b",
			         name, s.exp_flags, monster_destroyed);
			ok = 1'b0;
		end
		n_run++;
		if (!ok) begin
			n_fail++;
		end
		$display("test %-16s %s", name, ok ? "ok" : "failed");
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		bright = 1'b0;
		left = 1'b0;
		right = 1'b0;
		fire = 1'b0;
		restart = 1'b0;
		h_count = '0;
		v_count = '0;
		n_run = 0;
		n_fail = 0;

		add_step("reset_dark", A_DARK, 0, P_ABS, 450, 450, COLOR_BLACK, 5'h00);
		add_step("reset_body", A_IDLE, 0, P_ABS, 450, 450, COLOR_GREEN, 5'h00);
		add_step("reset_head", A_IDLE, 0, P_ABS, 450, 446, COLOR_GREEN, 5'h00);
		add_step("reset_mons_0", A_IDLE, 0, P_ABS, 250, 100, COLOR_RED, 5'h00);
		add_step("reset_mons_1", A_IDLE, 0, P_ABS, 350, 100, COLOR_RED, 5'h00);
		add_step("reset_mons_2", A_IDLE, 0, P_ABS, 450, 100, COLOR_RED, 5'h00);
		add_step("reset_mons_3", A_IDLE, 0, P_ABS, 550, 100, COLOR_RED, 5'h00);
		add_step("reset_mons_4", A_IDLE, 0, P_ABS, 650, 100, COLOR_RED, 5'h00);
		add_step("reset_gap", A_IDLE, 0, P_ABS, 300, 100, COLOR_BLACK, 5'h00);
		add_step("right_20", A_RIGHT, 20, P_TANK, 0, 450, COLOR_GREEN, 5'h00);
		add_step("right_20_side", A_IDLE, 0, P_TANK, 12, 450, COLOR_BLACK, 5'h00);
		add_step("left_30", A_LEFT, 30, P_TANK, 0, 450, COLOR_GREEN, 5'h00);
		// crosses 800 and comes back in at 150
		add_step("wrap_right", A_RIGHT, 200, P_TANK, 0, 450, COLOR_GREEN, 5'h00);
		add_step("wrap_right_side", A_IDLE, 0, P_TANK, 12, 450, COLOR_BLACK, 5'h00);
		add_step("wrap_left", A_LEFT, 40, P_TANK, 0, 450, COLOR_GREEN, 5'h00);
		add_step("wrap_left_side", A_IDLE, 0, P_TANK, -12, 450, COLOR_BLACK, 5'h00);
		// one column past the body edge turns green if the tank stepped
		add_step("fire_freeze", A_FIRE_RIGHT, 1, P_TANK, 11, 450, COLOR_BLACK, 5'h00);
		add_step("to_300", A_LEFT, 225, P_TANK, 0, 450, COLOR_GREEN, 5'h00);
		add_step("fire_300", A_FIRE, 1, P_ABS, 300, 450, COLOR_BLUE, 5'h00);
		// the opening negedge adds the hundredth edge
		add_step("flight_k100", A_IDLE, 99, P_ABS, 300, 350, COLOR_BLUE, 5'h00);
		add_step("flight_top", A_IDLE, 329, P_ABS, 300, 33, COLOR_BLACK, 5'h00);
		// where the bullet would be had it kept climbing
		add_step("flight_gone", A_IDLE, 0, P_ABS, 300, 19, COLOR_BLACK, 5'h00);
		add_step("burst_4", A_FIRE, 4, P_SLOT0, 0, -1, COLOR_BLUE, 5'h00);
		add_step("burst_slot0", A_IDLE, 50, P_SLOT0, 0, -1, COLOR_BLUE, 5'h00);
		add_step("burst_slot2", A_IDLE, 0, P_SLOT2, 0, 1, COLOR_BLUE, 5'h00);
		add_step("burst_no_fourth", A_IDLE, 0, P_SLOT2, 0, 2, COLOR_BLACK, 5'h00);
		// slot 0 just retired and slot 1 sits in the top band
		add_step("burst_slot1", A_IDLE, 361, P_SLOT1, 0, -1, COLOR_BLUE, 5'h00);
		// a slot 2 that failed to retire would still cover row 33
		add_step("burst_retire", A_IDLE, 1, P_ABS, 300, 33, COLOR_BLACK, 5'h00);
		add_step("to_450", A_RIGHT, 75, P_TANK, 0, 450, COLOR_GREEN, 5'h00);
		add_step("hit_450", A_SHOOT, 400, P_ABS, 450, 100, COLOR_BLACK, 5'b00100);
		add_step("to_250", A_LEFT, 100, P_TANK, 0, 450, COLOR_GREEN, 5'b00100);
		add_step("hit_250", A_SHOOT, 400, P_ABS, 250, 100, COLOR_BLACK, 5'b00101);
		add_step("to_350", A_RIGHT, 50, P_TANK, 0, 450, COLOR_GREEN, 5'b00101);
		add_step("hit_350", A_SHOOT, 400, P_ABS, 350, 100, COLOR_BLACK, 5'b00111);
		add_step("to_550", A_RIGHT, 100, P_TANK, 0, 450, COLOR_GREEN, 5'b00111);
		add_step("hit_550", A_SHOOT, 400, P_ABS, 550, 100, COLOR_BLACK, 5'b01111);
		add_step("to_650", A_RIGHT, 50, P_TANK, 0, 450, COLOR_GREEN, 5'b01111);
		add_step("hit_650", A_SHOOT, 400, P_ABS, 650, 100, COLOR_CYAN, 5'b11111);
		add_step("cleared_sweep", A_IDLE, 0, P_SWEEP, 0, 0, COLOR_CYAN, 5'b11111);
		add_step("cleared_dark", A_DARK, 0, P_ABS, 650, 100, COLOR_BLACK, 5'b11111);
		add_step("restart", A_RESTART, 1, P_ABS, 450, 450, COLOR_GREEN, 5'h00);
		add_step("restart_mons", A_IDLE, 0, P_ABS, 450, 100, COLOR_RED, 5'h00);

		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		for (int i = 0; i < steps.size(); i++) begin
			run_step(steps[i], step_names[i]);
		end

		$display("tests: %0d run, %0d failed", n_run, n_fail);
		if (n_fail == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
